// ==== Makefile ====
.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f sources.f --top-module knightCommandBench

sim:
	verilator --binary --timing --assert -f sources.f --top-module knightCommandBench \
		-o knightSim
	./obj_dir/knightSim > sim.log 2>&1 || true
	cat sim.log
	grep -q '^>>> PASS$$' sim.log

clean:
	rm -rf obj_dir sim.log

// ==== bench/knightCommandBench.sv ====
`timescale 1ns/1ps

module knightCommandBench;

  localparam int CLKS_PER_BIT = 8;
  localparam int CAL_CYCLES = 200;
  localparam int SQUARE_CYCLES = 50;
  // Enough for calibration or a three square move plus both serial frames
  localparam int RESPONSE_TIMEOUT = 3000;
  localparam logic [7:0] ACK = 8'hA5;
  localparam logic [7:0] NACK = 8'hEE;

  logic clk;
  logic reset;
  logic rx;
  logic tx;
  knightPkg::boardCoord xPos;
  knightPkg::boardCoord yPos;
  knightPkg::headingCode heading;
  logic moving;
  logic calDone;
  logic busy;

  int errorCount;
  int testsRun;
  int testsFailed;
  logic [15:0] lfsrState;
  // Board model, the knight wakes up on (2,4) uncalibrated
  int modelX;
  int modelY;
  logic modelCal;
  // Only the monitor below writes this
  int movingCycles = 0;

  knightCommandTop #(
    .CLKS_PER_BIT(CLKS_PER_BIT), .CAL_CYCLES(CAL_CYCLES), .SQUARE_CYCLES(SQUARE_CYCLES)
  ) DUT (
    .clk(clk), .reset(reset), .rx(rx), .tx(tx), .xPos(xPos), .yPos(yPos),
    .heading(heading), .moving(moving), .calDone(calDone), .busy(busy)
  );

  always #50 clk = ~clk;

  // Outputs settle after the rising edge so they are looked at on the falling one
  always @(negedge clk) begin
    if (moving) movingCycles = movingCycles + 1;
  end

  //////////////////////////////
  // Random numbers and the board model
  //////////////////////////////

  // Galois LFSR, one step per bit handed out
  function automatic logic takeBit();
    logic outBit;
    outBit = lfsrState[0];
    lfsrState = lfsrState >> 1;
    if (outBit) lfsrState = lfsrState ^ 16'hB400;
    return outBit;
  endfunction

  function automatic logic [7:0] takeBits(input int count);
    logic [7:0] value;
    value = '0;
    for (int i = 0; i < count; i++) value = {value[6:0], takeBit()};
    return value;
  endfunction

  // Predicts the response and moves the model knight when the command is accepted
  function automatic logic [7:0] predictResponse(input logic [15:0] cmd);
    int dx;
    int dy;
    int nx;
    int ny;
    int count;
    dx = 0;
    dy = 0;
    count = int'(cmd[3:0]);
    if (cmd[15:12] == 4'd2) begin
      modelCal = 1'b1;
      return ACK;
    end
    if (cmd[15:12] != 4'd4) return NACK;
    // North raises y and east raises x
    case (cmd[11:4])
      8'h00: dy = 1;
      8'h3F: dx = -1;
      8'h7F: dy = -1;
      8'hC0: dx = 1;
      default: return NACK;
    endcase
    nx = modelX + dx * count;
    ny = modelY + dy * count;
    if (!modelCal || count == 0 || nx < 0 || nx > 4 || ny < 0 || ny > 4) return NACK;
    modelX = nx;
    modelY = ny;
    return ACK;
  endfunction

  //////////////////////////////
  // Serial driver and monitor
  //////////////////////////////

  task automatic sendByte(input logic [7:0] value);
    logic [9:0] frame;
    frame = {1'b1, value, 1'b0};
    @(posedge clk);
    for (int i = 0; i < 10; i++) begin
      rx <= frame[i];
      repeat (CLKS_PER_BIT) @(posedge clk);
    end
  endtask

  // High byte goes first
  task automatic sendWord(input logic [15:0] cmd);
    sendByte(cmd[15:8]);
    sendByte(cmd[7:0]);
  endtask

  // Waits for a start bit on tx and samples each bit in its middle
  task automatic receiveByte(output logic [7:0] value, output logic got);
    int waited;
    value = '0;
    got = 1'b0;
    waited = 0;
    @(negedge clk);
    while (tx !== 1'b0 && waited < RESPONSE_TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (tx !== 1'b0) return;
    repeat (CLKS_PER_BIT / 2) @(negedge clk);
    for (int i = 0; i < 8; i++) begin
      repeat (CLKS_PER_BIT) @(negedge clk);
      value[i] = tx;
    end
    repeat (CLKS_PER_BIT) @(negedge clk);
    got = (tx === 1'b1);
  endtask

  //////////////////////////////
  // Checking
  //////////////////////////////

  task automatic reportMismatch(input string testName, input string what,
                                input int expected, input int actual);
    $display("CHECK FAILED %s %s expected %0h actual %0h", testName, what, expected, actual);
    errorCount++;
  endtask

  // The response can start before the last stop bit is over, so both run side by side
  task automatic runCommand(input string testName, input logic [15:0] cmd);
    logic [7:0] expResp;
    logic [7:0] resp;
    logic got;
    int movingBefore;
    expResp = predictResponse(cmd);
    movingBefore = movingCycles;
    fork
      sendWord(cmd);
      receiveByte(resp, got);
    join
    if (!got) begin
      $display("%s: no valid response frame came back on tx for command %h", testName, cmd);
      errorCount++;
      return;
    end
    if (resp != expResp) reportMismatch(testName, "response", int'(expResp), int'(resp));
    if (int'(xPos) != modelX) reportMismatch(testName, "xPos", modelX, int'(xPos));
    if (int'(yPos) != modelY) reportMismatch(testName, "yPos", modelY, int'(yPos));
    if (expResp == ACK && cmd[15:12] == 4'd2 && calDone !== 1'b1) begin
      reportMismatch(testName, "calDone", 1, int'(calDone));
    end
    if (expResp == ACK && cmd[15:12] == 4'd4) begin
      if (movingCycles == movingBefore) begin
        $display("%s: moving never went high during accepted move %h", testName, cmd);
        errorCount++;
      end
      if (heading != cmd[11:4]) reportMismatch(testName, "heading", int'(cmd[11:4]), int'(heading));
    end
  endtask

  task automatic finishTest(input string testName, input int startErrors);
    testsRun++;
    if (errorCount == startErrors) begin
      $display("test %s passed", testName);
    end else begin
      testsFailed++;
      $display("test %s failed with %0d errors", testName, errorCount - startErrors);
    end
  endtask

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin
    logic [15:0] cmd;
    logic [7:0] pick;
    logic [7:0] h;
    logic [7:0] count;
    int startErrors;
    clk = 1'b0;
    reset = 1'b1;
    rx = 1'b1;
    errorCount = 0;
    testsRun = 0;
    testsFailed = 0;
    lfsrState = 16'd56;
    modelX = 2;
    modelY = 4;
    modelCal = 1'b0;
    repeat (4) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);

    startErrors = errorCount;
    if (tx !== 1'b1) reportMismatch("afterReset", "tx", 1, int'(tx));
    if (moving !== 1'b0) reportMismatch("afterReset", "moving", 0, int'(moving));
    if (calDone !== 1'b0) reportMismatch("afterReset", "calDone", 0, int'(calDone));
    if (busy !== 1'b0) reportMismatch("afterReset", "busy", 0, int'(busy));
    if (int'(xPos) != 2) reportMismatch("afterReset", "xPos", 2, int'(xPos));
    if (int'(yPos) != 4) reportMismatch("afterReset", "yPos", 4, int'(yPos));
    finishTest("afterReset", startErrors);

    // One square south would fit the board, only the missing calibration refuses it
    startErrors = errorCount;
    runCommand("moveBeforeCal", {4'd4, 8'h7F, 4'd1});
    finishTest("moveBeforeCal", startErrors);

    startErrors = errorCount;
    runCommand("calibration", {4'd2, 8'h00, 4'd0});
    finishTest("calibration", startErrors);

    startErrors = errorCount;
    for (int n = 0; n < 40; n++) begin
      pick = takeBits(2);
      case (pick)
        8'd0: h = 8'h00;
        8'd1: h = 8'h3F;
        8'd2: h = 8'h7F;
        default: h = 8'hC0;
      endcase
      count = takeBits(2);
      runCommand("randomMoves", {4'd4, h, count[3:0]});
    end
    finishTest("randomMoves", startErrors);

    startErrors = errorCount;
    // Opcodes other than calibrate and move
    for (int n = 0; n < 4; n++) begin
      pick = takeBits(4);
      if (pick[3:0] == 4'd2 || pick[3:0] == 4'd4) pick[3] = ~pick[3];
      h = takeBits(8);
      count = takeBits(4);
      runCommand("invalidCommands", {pick[3:0], h, count[3:0]});
    end
    // Headings off the four legal codes, flipping bit 0 never lands on another one
    for (int n = 0; n < 4; n++) begin
      h = takeBits(8);
      if (h == 8'h00 || h == 8'h3F || h == 8'h7F || h == 8'hC0) h[0] = ~h[0];
      count = takeBits(2) + 8'd1;
      runCommand("invalidCommands", {4'd4, h, count[3:0]});
    end
    cmd = {4'd4, 8'h3F, 4'd0};
    runCommand("invalidCommands", cmd);
    finishTest("invalidCommands", startErrors);

    $display("tests run %0d, tests failed %0d, checks failed %0d",
             testsRun, testsFailed, errorCount);
    if (errorCount == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// ==== source/boardTracker.sv ====
`timescale 1ns/1ps

module boardTracker #(
  parameter int SQUARE_CYCLES = 2000000
) (
  input  logic clk,
  input  logic reset,
  moveIf.tracker move,
  output knightPkg::boardCoord xPos,
  output knightPkg::boardCoord yPos,
  output knightPkg::headingCode heading
);

  localparam int TIMER_WIDTH = $clog2(SQUARE_CYCLES);

  logic headingKnown;
  logic fitsBoard;
  // Five bits so a 15 square request cannot wrap back onto the board
  logic [4:0] northReach;
  logic [4:0] eastReach;
  knightPkg::squareCount squaresLeft;
  logic [TIMER_WIDTH-1:0] timer;

  //////////////////////////////
  // Legality of the presented move
  //////////////////////////////

  assign northReach = {2'b00, yPos} + {1'b0, move.squares};
  assign eastReach = {2'b00, xPos} + {1'b0, move.squares};

  always_comb begin
    headingKnown = 1'b1;
    fitsBoard = 1'b0;
    case (move.heading)
      knightPkg::HEADING_NORTH: fitsBoard = northReach <= 5'(knightPkg::BOARD_MAX);
      knightPkg::HEADING_SOUTH: fitsBoard = move.squares <= {1'b0, yPos};
      knightPkg::HEADING_EAST:  fitsBoard = eastReach <= 5'(knightPkg::BOARD_MAX);
      knightPkg::HEADING_WEST:  fitsBoard = move.squares <= {1'b0, xPos};
      default: headingKnown = 1'b0;
    endcase
  end

  assign move.legal = headingKnown && (move.squares != '0) && fitsBoard;

  //////////////////////////////
  // Square stepping
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      xPos <= knightPkg::START_X;
      yPos <= knightPkg::START_Y;
      heading <= knightPkg::HEADING_NORTH;
      squaresLeft <= '0;
      timer <= '0;
      move.moving <= 1'b0;
      move.done <= 1'b0;
    end else begin
      move.done <= 1'b0;
      if (move.start) begin
        // Control has already vetted this move, so it is taken unconditionally
        heading <= move.heading;
        squaresLeft <= move.squares;
        timer <= TIMER_WIDTH'(SQUARE_CYCLES - 1);
        move.moving <= 1'b1;
      end else if (move.moving) begin
        if (timer != '0) begin
          timer <= timer - 1'b1;
        end else begin
          case (heading)
            knightPkg::HEADING_NORTH: yPos <= yPos + 1'b1;
            knightPkg::HEADING_SOUTH: yPos <= yPos - 1'b1;
            knightPkg::HEADING_EAST:  xPos <= xPos + 1'b1;
            knightPkg::HEADING_WEST:  xPos <= xPos - 1'b1;
            default: ;
          endcase
          squaresLeft <= squaresLeft - 1'b1;
          timer <= TIMER_WIDTH'(SQUARE_CYCLES - 1);
          // Last square taken, done lines up with the final position
          if (squaresLeft == 4'd1) begin
            move.moving <= 1'b0;
            move.done <= 1'b1;
          end
        end
      end
    end
  end

  offBoard: assert property (@(posedge clk) disable iff (reset)
    (xPos <= knightPkg::BOARD_MAX) && (yPos <= knightPkg::BOARD_MAX));

endmodule

// ==== source/commandAssembler.sv ====
`timescale 1ns/1ps

module commandAssembler (
  input  logic clk,
  input  logic reset,
  input  knightPkg::respByte data,
  input  logic dataStrobe,
  output knightPkg::cmdWord command,
  output logic commandValid
);

  // Low means the next byte is the high half of a command
  logic phase;
  knightPkg::respByte highByte;

  always_ff @(posedge clk) begin
    if (reset) begin
      phase <= 1'b0;
      commandValid <= 1'b0;
    end else begin
      commandValid <= dataStrobe && phase;
      if (dataStrobe) phase <= !phase;
    end
  end

  // The word stays put until the next pair completes
  always_ff @(posedge clk) begin
    if (dataStrobe && !phase) highByte <= data;
    if (dataStrobe && phase) command <= {highByte, data};
  end

endmodule

// ==== source/knightCommandTop.sv ====
`timescale 1ns/1ps

module knightCommandTop #(
  parameter int CLKS_PER_BIT = 434,
  parameter int CAL_CYCLES = 1000000,
  parameter int SQUARE_CYCLES = 2000000
) (
  input  logic clk,
  input  logic reset,
  input  logic rx,
  output logic tx,
  output knightPkg::boardCoord xPos,
  output knightPkg::boardCoord yPos,
  output knightPkg::headingCode heading,
  output logic moving,
  output logic calDone,
  output logic busy
);

  // Receive path
  knightPkg::respByte rxData;
  logic rxStrobe;
  knightPkg::cmdWord command;
  logic commandValid;

  // Response path
  knightPkg::respByte txData;
  logic txStart;
  logic txBusy;

  moveIf moveBus ();

  assign moving = moveBus.moving;

  uartReceiver #(.CLKS_PER_BIT(CLKS_PER_BIT)) receiver (
    .clk(clk), .reset(reset), .rx(rx), .data(rxData), .dataStrobe(rxStrobe)
  );

  commandAssembler assembler (
    .clk(clk), .reset(reset), .data(rxData), .dataStrobe(rxStrobe),
    .command(command), .commandValid(commandValid)
  );

  knightControl #(.CAL_CYCLES(CAL_CYCLES)) control (
    .clk(clk), .reset(reset), .command(command), .commandValid(commandValid),
    .txData(txData), .txStart(txStart), .txBusy(txBusy),
    .calDone(calDone), .busy(busy), .move(moveBus)
  );

  boardTracker #(.SQUARE_CYCLES(SQUARE_CYCLES)) tracker (
    .clk(clk), .reset(reset), .move(moveBus),
    .xPos(xPos), .yPos(yPos), .heading(heading)
  );

  uartTransmitter #(.CLKS_PER_BIT(CLKS_PER_BIT)) transmitter (
    .clk(clk), .reset(reset), .txData(txData), .txStart(txStart),
    .tx(tx), .txBusy(txBusy)
  );

endmodule

// ==== source/knightControl.sv ====
`timescale 1ns/1ps

module knightControl #(
  parameter int CAL_CYCLES = 1000000
) (
  input  logic clk,
  input  logic reset,
  input  knightPkg::cmdWord command,
  input  logic commandValid,
  output knightPkg::respByte txData,
  output logic txStart,
  input  logic txBusy,
  output logic calDone,
  output logic busy,
  moveIf.controller move
);

  localparam int CAL_WIDTH = $clog2(CAL_CYCLES);
  // Decode, count reload and the calDone flop eat three of the cycles
  localparam int CAL_LOAD = CAL_CYCLES - 3;

  knightPkg::controlState state;
  knightPkg::cmdWord cmdReg;
  knightPkg::opcodeField opcode;
  knightPkg::respByte respReg;
  logic decodeStep;
  logic accept;
  logic [CAL_WIDTH-1:0] calCount;

  //////////////////////////////
  // Command fields
  //////////////////////////////

  assign opcode = cmdReg[15:12];
  assign move.heading = cmdReg[11:4];
  assign move.squares = cmdReg[3:0];

  // New words only count while nothing else is in flight
  assign busy = (state != knightPkg::idle) || decodeStep;
  assign accept = commandValid && !busy;

  // All three move checks are made in the decode cycle, start fires then too
  assign move.start = (state == knightPkg::idle) && decodeStep &&
                      (opcode == knightPkg::OPCODE_MOVE) && calDone && move.legal;

  assign txStart = (state == knightPkg::respond);
  assign txData = respReg;

  always_ff @(posedge clk) begin
    if (accept) cmdReg <= command;
  end

  //////////////////////////////
  // Control FSM
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= knightPkg::idle;
      decodeStep <= 1'b0;
      calDone <= 1'b0;
      calCount <= '0;
    end else begin
      decodeStep <= accept;
      case (state)
        knightPkg::idle: begin
          if (decodeStep) begin
            if (opcode == knightPkg::OPCODE_CAL) begin
              state <= knightPkg::calibrate;
              calCount <= CAL_WIDTH'(CAL_LOAD);
            end else if (move.start) begin
              state <= knightPkg::moveWait;
            end else begin
              // Unknown opcode or a refused move goes straight to NACK
              state <= knightPkg::respond;
            end
          end
        end
        knightPkg::calibrate: begin
          if (calCount == '0) begin
            calDone <= 1'b1;
            state <= knightPkg::respond;
          end else begin
            calCount <= calCount - 1'b1;
          end
        end
        knightPkg::moveWait: begin
          if (move.done) state <= knightPkg::respond;
        end
        knightPkg::respond: state <= knightPkg::respondWait;
        // Transmitter raised busy on the edge after txStart
        knightPkg::respondWait: begin
          if (!txBusy) state <= knightPkg::idle;
        end
        default: state <= knightPkg::idle;
      endcase
    end
  end

  // Anything that gets past idle into calibrate or moveWait ends in ACK
  always_ff @(posedge clk) begin
    if (state == knightPkg::calibrate || state == knightPkg::moveWait) begin
      respReg <= knightPkg::RESP_ACK;
    end else if (state == knightPkg::idle) begin
      respReg <= knightPkg::RESP_NACK;
    end
  end

  // An ACK only ever leaves once calibration has finished
  ackWithoutCal: assert property (@(posedge clk) disable iff (reset)
    (txStart && (txData == knightPkg::RESP_ACK)) |-> calDone);

endmodule

// ==== source/knightPkg.sv ====
package knightPkg;

  //////////////////////////////
  // Field and word types
  //////////////////////////////

  // A command arrives as two UART bytes, high byte first
  typedef logic [15:0] cmdWord;

  // Bits 15 to 12 of the command word
  typedef logic [3:0] opcodeField;

  // Bits 11 to 4, the direction of travel
  typedef logic [7:0] headingCode;

  // Bits 3 to 0, how many squares to travel
  typedef logic [3:0] squareCount;

  // One axis of the 5 by 5 board
  typedef logic [2:0] boardCoord;

  // The single byte sent back for each command
  typedef logic [7:0] respByte;

  //////////////////////////////
  // Protocol constants
  //////////////////////////////

  localparam opcodeField OPCODE_CAL  = 4'd2;
  localparam opcodeField OPCODE_MOVE = 4'd4;

  localparam respByte RESP_ACK  = 8'hA5;
  localparam respByte RESP_NACK = 8'hEE;

  // Only these four codes are legal, anything else is refused
  localparam headingCode HEADING_NORTH = 8'h00;
  localparam headingCode HEADING_WEST  = 8'h3F;
  localparam headingCode HEADING_SOUTH = 8'h7F;
  localparam headingCode HEADING_EAST  = 8'hC0;

  // Board limits and the square the knight wakes up on
  localparam boardCoord BOARD_MAX = 3'd4;
  localparam boardCoord START_X   = 3'd2;
  localparam boardCoord START_Y   = 3'd4;

  // Control FSM states
  typedef enum logic [2:0] {idle, calibrate, moveWait, respond, respondWait} controlState;

endpackage

// ==== source/moveIf.sv ====
`timescale 1ns/1ps

// Move request from control to the board tracker, with its results coming back
interface moveIf;

  // Control side: a one cycle start with heading and squares held alongside
  logic start;
  knightPkg::headingCode heading;
  knightPkg::squareCount squares;

  // Tracker side: legality is combinational for whatever is presented now
  logic legal;
  logic moving;
  logic done;

  modport controller (output start, heading, squares, input legal, done);
  modport tracker (input start, heading, squares, output legal, moving, done);

endinterface

// ==== source/uartReceiver.sv ====
`timescale 1ns/1ps

module uartReceiver #(
  parameter int CLKS_PER_BIT = 434
) (
  input  logic clk,
  input  logic reset,
  input  logic rx,
  output knightPkg::respByte data,
  output logic dataStrobe
);

  localparam int COUNT_WIDTH = $clog2(CLKS_PER_BIT);

  // Two flop synchronizer, rxSync[1] is the usable copy
  logic [1:0] rxSync;
  logic rxPrev;
  logic active;
  logic [COUNT_WIDTH-1:0] clkCount;
  // Bit 0 is the start bit, 1 to 8 are data, 9 is the stop bit
  logic [3:0] bitIndex;
  logic sampleNow;
  knightPkg::respByte shiftReg;

  // Count reaches zero in the middle of each bit
  assign sampleNow = active && (clkCount == '0);
  assign data = shiftReg;

  //////////////////////////////
  // Frame sequencing
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      rxSync <= 2'b11;
      rxPrev <= 1'b1;
      active <= 1'b0;
      clkCount <= '0;
      bitIndex <= '0;
      dataStrobe <= 1'b0;
    end else begin
      rxSync <= {rxSync[0], rx};
      rxPrev <= rxSync[1];
      dataStrobe <= 1'b0;
      if (!active) begin
        // Falling edge opens a frame, first sample lands half a bit later
        if (rxPrev && !rxSync[1]) begin
          active <= 1'b1;
          clkCount <= COUNT_WIDTH'(CLKS_PER_BIT / 2 - 1);
          bitIndex <= '0;
        end
      end else if (!sampleNow) begin
        clkCount <= clkCount - 1'b1;
      end else begin
        clkCount <= COUNT_WIDTH'(CLKS_PER_BIT - 1);
        bitIndex <= bitIndex + 1'b1;
        if (bitIndex == 4'd0) begin
          // Line back high at mid start bit means it was only a glitch
          if (rxSync[1]) active <= 1'b0;
        end else if (bitIndex == 4'd9) begin
          // A low stop bit is a framing error and the byte is thrown away
          active <= 1'b0;
          dataStrobe <= rxSync[1];
        end
      end
    end
  end

  // Data bits arrive LSB first so they shift in from the top
  always_ff @(posedge clk) begin
    if (sampleNow && (bitIndex >= 4'd1) && (bitIndex <= 4'd8)) begin
      shiftReg <= {rxSync[1], shiftReg[7:1]};
    end
  end

endmodule

// ==== source/uartTransmitter.sv ====
`timescale 1ns/1ps

module uartTransmitter #(
  parameter int CLKS_PER_BIT = 434
) (
  input  logic clk,
  input  logic reset,
  input  knightPkg::respByte txData,
  input  logic txStart,
  output logic tx,
  output logic txBusy
);

  localparam int COUNT_WIDTH = $clog2(CLKS_PER_BIT);

  // Eight data bits followed by the stop bit
  logic [8:0] shiftReg;
  logic [3:0] bitsLeft;
  logic [COUNT_WIDTH-1:0] clkCount;
  logic launch;
  logic bitEnd;

  assign launch = txStart && !txBusy;
  assign bitEnd = txBusy && (clkCount == '0);

  always_ff @(posedge clk) begin
    if (reset) begin
      tx <= 1'b1;
      txBusy <= 1'b0;
      bitsLeft <= '0;
      clkCount <= '0;
    end else if (launch) begin
      // Start bit goes out on the very next cycle
      tx <= 1'b0;
      txBusy <= 1'b1;
      bitsLeft <= 4'd9;
      clkCount <= COUNT_WIDTH'(CLKS_PER_BIT - 1);
    end else if (txBusy && !bitEnd) begin
      clkCount <= clkCount - 1'b1;
    end else if (bitEnd && (bitsLeft != '0)) begin
      tx <= shiftReg[0];
      bitsLeft <= bitsLeft - 1'b1;
      clkCount <= COUNT_WIDTH'(CLKS_PER_BIT - 1);
    end else if (bitEnd) begin
      // Stop bit has run its full period
      txBusy <= 1'b0;
    end
  end

  // Stop bit rides in the top so it falls out last, LSB leaves first
  always_ff @(posedge clk) begin
    if (launch) shiftReg <= {1'b1, txData};
    else if (bitEnd && (bitsLeft != '0)) shiftReg <= {1'b1, shiftReg[8:1]};
  end

  // Control must wait out the whole frame before asking for another byte
  txStartWhileBusy: assert property (@(posedge clk) disable iff (reset) txStart |-> !txBusy);

endmodule

// ==== sources.f ====
source/knightPkg.sv
source/moveIf.sv
source/uartReceiver.sv
source/uartTransmitter.sv
source/commandAssembler.sv
source/knightControl.sv
source/boardTracker.sv
source/knightCommandTop.sv
bench/knightCommandBench.sv
